/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* include/i2c_params.svh */
`ifndef I2C_PARAMS_SVH
`define I2C_PARAMS_SVH

// quarter-bit prescale value
`define I2C_PRESCALE_W 16

// filter sample-rate divider
`define I2C_DFSR_W 16

// samples in the majority vote
`define I2C_FILT_DEPTH 3

`endif

/* project.f */
+incdir+include
source/i2c_pkg.sv
source/i2c_bus_monitor.sv
source/i2c_bit_ctl.sv
source/i2c_byte_ctl.sv
source/i2c_master_top.sv
verif/tb_clock.sv
verif/i2c_slave_model.sv
verif/i2c_master_assert.sv
verif/tb_i2c_master.sv

/* source/i2c_bit_ctl.sv */
`include "i2c_params.svh"

module i2c_bit_ctl (
    input  logic                       sysclk,
    input  logic                       nReset,
    input  logic                       enable_i,
    input  logic [`I2C_PRESCALE_W-1:0] prescale_i,
    input  i2c_pkg::bit_cmd_e          cmd_i,
    input  logic                       din_i,
    input  logic                       scl_f_i,
    input  logic                       sda_f_i,
    input  logic                       al_i,
    output logic                       done_o,
    output logic                       dout_o,
    output logic                       scl_oen_o,
    output logic                       sda_oen_o,
    output logic                       scl_o,
    output logic                       sda_o,
    output logic                       sda_chk_o
);
    i2c_pkg::bit_cmd_e          cmd_q;
    i2c_pkg::bit_cmd_e          cmd_sel;
    logic [1:0]                 phase_q;
    logic [1:0]                 ph_nxt;
    logic [`I2C_PRESCALE_W-1:0] cnt_q;
    logic                       din_q;
    logic                       din_sel;
    logic                       al_q;
    logic                       al_rise;
    logic                       idle;
    logic                       stretch;
    logic [1:0]                 next_lines;

    assign scl_o = 1'b0;    // open drain, only oen toggles
    assign sda_o = 1'b0;

    assign idle      = (cmd_q == i2c_pkg::BIT_IDLE);
    assign al_rise   = al_i & ~al_q;
    assign stretch   = (phase_q == 2'd1) && !scl_f_i;   // slave holds SCL low
    assign sda_chk_o = (cmd_q == i2c_pkg::BIT_WRITE);

    assign cmd_sel = idle ? cmd_i : cmd_q;
    assign din_sel = idle ? din_i : din_q;
    assign ph_nxt  = idle ? 2'd0 : phase_q + 2'd1;

    // {scl_oen, sda_oen} of the phase being entered
    always_comb
    begin
        case (cmd_sel)
            i2c_pkg::BIT_START:
            begin
                next_lines = {ph_nxt != 2'd3, ph_nxt < 2'd2};
            end
            i2c_pkg::BIT_STOP:
            begin
                next_lines = {ph_nxt != 2'd0, ph_nxt == 2'd3};
            end
            i2c_pkg::BIT_WRITE:
            begin
                next_lines = {ph_nxt[1] ^ ph_nxt[0], din_sel};
            end
            i2c_pkg::BIT_READ:
            begin
                next_lines = {ph_nxt[1] ^ ph_nxt[0], 1'b1};
            end
            default:
            begin
                next_lines = 2'b11;
            end
        endcase
    end

    always_ff @(posedge sysclk or negedge nReset)
    begin
        if (!nReset)
        begin
            cmd_q     <= i2c_pkg::BIT_IDLE;
            phase_q   <= 2'd0;
            cnt_q     <= '0;
            din_q     <= 1'b1;
            al_q      <= 1'b0;
            done_o    <= 1'b0;
            dout_o    <= 1'b1;
            scl_oen_o <= 1'b1;
            sda_oen_o <= 1'b1;
        end
        else if (!enable_i)
        begin
            cmd_q     <= i2c_pkg::BIT_IDLE;
            phase_q   <= 2'd0;
            cnt_q     <= '0;
            din_q     <= 1'b1;
            al_q      <= 1'b0;
            done_o    <= 1'b0;
            dout_o    <= 1'b1;
            scl_oen_o <= 1'b1;
            sda_oen_o <= 1'b1;
        end
        else
        begin
            al_q   <= al_i;
            done_o <= 1'b0;
            if (al_rise && !idle)
            begin
                cmd_q     <= i2c_pkg::BIT_IDLE;   // lost the bus, let go
                scl_oen_o <= 1'b1;
                sda_oen_o <= 1'b1;
                done_o    <= 1'b1;
            end
            else if (idle)
            begin
                if (cmd_i != i2c_pkg::BIT_IDLE)
                begin
                    cmd_q                  <= cmd_i;
                    din_q                  <= din_i;
                    phase_q                <= 2'd0;
                    cnt_q                  <= prescale_i;
                    {scl_oen_o, sda_oen_o} <= next_lines;
                end
            end
            else if (stretch)
                cnt_q <= prescale_i;
            else if (cnt_q != '0)
                cnt_q <= cnt_q - 1'b1;
            else
            begin
                if (phase_q == 2'd1)
                    dout_o <= sda_f_i;    // mid SCL high
                if (phase_q == 2'd3)
                begin
                    cmd_q  <= i2c_pkg::BIT_IDLE;
                    done_o <= 1'b1;
                end
                else
                begin
                    phase_q                <= ph_nxt;
                    cnt_q                  <= prescale_i;
                    {scl_oen_o, sda_oen_o} <= next_lines;
                end
            end
        end
    end

endmodule

/* source/i2c_bus_monitor.sv */
`include "i2c_params.svh"

module i2c_bus_monitor (
    input  logic                   sysclk,
    input  logic                   nReset,
    input  logic                   enable_i,
    input  logic [`I2C_DFSR_W-1:0] dfsr_i,
    input  logic                   scl_i,
    input  logic                   sda_i,
    input  logic                   sda_drive_i,
    input  logic                   sda_chk_i,
    output logic                   scl_f_o,
    output logic                   sda_f_o,
    output logic                   busy_o,
    output logic                   al_o
);
    logic [1:0]                 scl_sync;
    logic [1:0]                 sda_sync;
    logic [`I2C_DFSR_W-1:0]     smp_cnt;
    logic [`I2C_FILT_DEPTH-1:0] scl_sr;
    logic [`I2C_FILT_DEPTH-1:0] sda_sr;
    logic                       scl_d;
    logic                       sda_d;
    logic                       drive_d;
    logic                       own_rel;
    logic                       smp_en;
    logic                       scl_high;
    logic                       start_det;
    logic                       stop_det;

    assign smp_en    = (smp_cnt == '0);
    assign scl_high  = scl_f_o & scl_d;
    assign start_det = scl_high & sda_d & ~sda_f_o;
    assign stop_det  = scl_high & ~sda_d & sda_f_o;

    always_ff @(posedge sysclk or negedge nReset)
    begin
        if (!nReset)
        begin
            scl_sync <= '1;
            sda_sync <= '1;
            smp_cnt  <= '0;
            scl_sr   <= '1;
            sda_sr   <= '1;
            scl_f_o  <= 1'b1;
            sda_f_o  <= 1'b1;
            scl_d    <= 1'b1;
            sda_d    <= 1'b1;
        end
        else
        begin
            scl_sync <= {scl_sync[0], scl_i};
            sda_sync <= {sda_sync[0], sda_i};
            smp_cnt  <= smp_en ? dfsr_i : smp_cnt - 1'b1;
            if (smp_en)
            begin
                scl_sr <= {scl_sr[`I2C_FILT_DEPTH-2:0], scl_sync[1]};
                sda_sr <= {sda_sr[`I2C_FILT_DEPTH-2:0], sda_sync[1]};
            end
            scl_f_o <= ($countones(scl_sr) > (`I2C_FILT_DEPTH / 2)); // majority vote
            sda_f_o <= ($countones(sda_sr) > (`I2C_FILT_DEPTH / 2));
            scl_d   <= scl_f_o;
            sda_d   <= sda_f_o;
        end
    end

    always_ff @(posedge sysclk or negedge nReset)
    begin
        if (!nReset)
        begin
            busy_o  <= 1'b0;
            al_o    <= 1'b0;
            own_rel <= 1'b0;
            drive_d <= 1'b1;
        end
        else if (!enable_i)
        begin
            busy_o  <= 1'b0;
            al_o    <= 1'b0;
            own_rel <= 1'b0;
            drive_d <= 1'b1;
        end
        else
        begin
            drive_d <= sda_drive_i;
            // master let SDA go with SCL high, i.e. its own STOP
            if (sda_drive_i && !drive_d && scl_f_o)
                own_rel <= 1'b1;
            else if (!scl_f_o)
                own_rel <= 1'b0;
            if (start_det)
                busy_o <= 1'b1;
            else if (stop_det)
                busy_o <= 1'b0;
            if (start_det && !sda_drive_i)
                al_o <= 1'b0;   // our own START
            else if (busy_o && ((sda_chk_i && sda_drive_i && !sda_f_o && scl_high) ||
                                (stop_det && !own_rel)))
                al_o <= 1'b1;
        end
    end

endmodule

/* source/i2c_byte_ctl.sv */
module i2c_byte_ctl (
    input  logic               sysclk,
    input  logic               nReset,
    input  logic               enable_i,
    input  logic               cmd_stb_i,
    input  i2c_pkg::byte_cmd_e cmd_i,
    input  logic [7:0]         data_i,
    input  logic               ack_i,
    input  logic               bit_done_i,
    input  logic               bit_dout_i,
    input  logic               al_i,
    output logic               cmd_ack_o,
    output logic [7:0]         data_o,
    output logic               rx_ack_o,
    output i2c_pkg::bit_cmd_e  bit_cmd_o,
    output logic               bit_din_o
);
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ONE  = 2'd1;   // START or STOP
    localparam logic [1:0] S_DATA = 2'd2;
    localparam logic [1:0] S_ACK  = 2'd3;

    i2c_pkg::byte_cmd_e cmd_q;
    logic [1:0]         state_q;
    logic [2:0]         bit_cnt_q;
    logic [7:0]         shift_q;
    logic               ack_q;
    logic               al_q;
    logic               is_write;
    logic               accept;

    assign is_write = (cmd_q == i2c_pkg::BYTE_WRITE);
    assign accept   = cmd_stb_i && (state_q == S_IDLE);
    assign data_o   = shift_q;

    always_ff @(posedge sysclk)
    begin
        if (accept)
        begin
            cmd_q   <= cmd_i;
            shift_q <= data_i;
            ack_q   <= ack_i;
        end
        else if ((state_q == S_DATA) && bit_done_i)
            shift_q <= {shift_q[6:0], bit_dout_i};   // msb first
    end

    always_ff @(posedge sysclk or negedge nReset)
    begin
        if (!nReset)
        begin
            state_q   <= S_IDLE;
            bit_cnt_q <= 3'd7;
            al_q      <= 1'b0;
            cmd_ack_o <= 1'b0;
            rx_ack_o  <= 1'b1;
            bit_cmd_o <= i2c_pkg::BIT_IDLE;
            bit_din_o <= 1'b1;
        end
        else if (!enable_i)
        begin
            state_q   <= S_IDLE;
            bit_cnt_q <= 3'd7;
            al_q      <= 1'b0;
            cmd_ack_o <= 1'b0;
            rx_ack_o  <= 1'b1;
            bit_cmd_o <= i2c_pkg::BIT_IDLE;
            bit_din_o <= 1'b1;
        end
        else
        begin
            al_q      <= al_i;
            cmd_ack_o <= 1'b0;
            bit_cmd_o <= i2c_pkg::BIT_IDLE;
            if (al_i && !al_q && (state_q != S_IDLE))
            begin
                state_q   <= S_IDLE;    // abandon, bit ctl already let go
                cmd_ack_o <= 1'b1;
            end
            else
            begin
                case (state_q)
                    S_IDLE:
                    begin
                        if (cmd_stb_i)
                        begin
                            bit_cnt_q <= 3'd7;
                            bit_din_o <= data_i[7];
                            case (cmd_i)
                                i2c_pkg::BYTE_START:
                                begin
                                    bit_cmd_o <= i2c_pkg::BIT_START;
                                    state_q   <= S_ONE;
                                end
                                i2c_pkg::BYTE_STOP:
                                begin
                                    bit_cmd_o <= i2c_pkg::BIT_STOP;
                                    state_q   <= S_ONE;
                                end
                                i2c_pkg::BYTE_WRITE:
                                begin
                                    bit_cmd_o <= i2c_pkg::BIT_WRITE;
                                    state_q   <= S_DATA;
                                end
                                default:
                                begin
                                    bit_cmd_o <= i2c_pkg::BIT_READ;
                                    state_q   <= S_DATA;
                                end
                            endcase
                        end
                    end
                    S_ONE:
                    begin
                        if (bit_done_i)
                        begin
                            cmd_ack_o <= 1'b1;
                            state_q   <= S_IDLE;
                        end
                    end
                    S_DATA:
                    begin
                        if (bit_done_i && (bit_cnt_q != 3'd0))
                        begin
                            bit_cnt_q <= bit_cnt_q - 3'd1;
                            bit_cmd_o <= is_write ? i2c_pkg::BIT_WRITE : i2c_pkg::BIT_READ;
                            bit_din_o <= shift_q[6];
                        end
                        else if (bit_done_i)
                        begin
                            // ninth bit, roles swap on SDA
                            bit_cmd_o <= is_write ? i2c_pkg::BIT_READ : i2c_pkg::BIT_WRITE;
                            bit_din_o <= is_write ? 1'b1 : ack_q;
                            state_q   <= S_ACK;
                        end
                    end
                    default:
                    begin
                        if (bit_done_i)
                        begin
                            if (is_write)
                                rx_ack_o <= bit_dout_i;
                            cmd_ack_o <= 1'b1;
                            state_q   <= S_IDLE;
                        end
                    end
                endcase
            end
        end
    end

endmodule

/* source/i2c_master_top.sv */
`include "i2c_params.svh"

module i2c_master_top (
    input  logic                       sysclk,
    input  logic                       nReset,
    input  logic                       enable_i,
    input  logic [`I2C_PRESCALE_W-1:0] prescale_i,
    input  logic [`I2C_DFSR_W-1:0]     dfsr_i,
    input  logic                       cmd_stb_i,
    input  i2c_pkg::byte_cmd_e         cmd_i,
    input  logic [7:0]                 data_i,
    input  logic                       ack_i,
    output logic                       cmd_ack_o,
    output logic [7:0]                 data_o,
    output logic                       rx_ack_o,
    output logic                       al_o,
    output logic                       busy_o,
    input  logic                       scl_i,
    output logic                       scl_o,
    output logic                       scl_oen_o,
    input  logic                       sda_i,
    output logic                       sda_o,
    output logic                       sda_oen_o
);
    i2c_pkg::bit_cmd_e bit_cmd;
    logic              bit_din;
    logic              bit_done;
    logic              bit_dout;
    logic              scl_f;
    logic              sda_f;
    logic              sda_chk;

    i2c_byte_ctl u_byte_ctl (
        .sysclk     (sysclk),
        .nReset     (nReset),
        .enable_i   (enable_i),
        .cmd_stb_i  (cmd_stb_i),
        .cmd_i      (cmd_i),
        .data_i     (data_i),
        .ack_i      (ack_i),
        .bit_done_i (bit_done),
        .bit_dout_i (bit_dout),
        .al_i       (al_o),
        .cmd_ack_o  (cmd_ack_o),
        .data_o     (data_o),
        .rx_ack_o   (rx_ack_o),
        .bit_cmd_o  (bit_cmd),
        .bit_din_o  (bit_din)
    );

    i2c_bit_ctl u_bit_ctl (
        .sysclk     (sysclk),
        .nReset     (nReset),
        .enable_i   (enable_i),
        .prescale_i (prescale_i),
        .cmd_i      (bit_cmd),
        .din_i      (bit_din),
        .scl_f_i    (scl_f),
        .sda_f_i    (sda_f),
        .al_i       (al_o),
        .done_o     (bit_done),
        .dout_o     (bit_dout),
        .scl_oen_o  (scl_oen_o),
        .sda_oen_o  (sda_oen_o),
        .scl_o      (scl_o),
        .sda_o      (sda_o),
        .sda_chk_o  (sda_chk)
    );

    i2c_bus_monitor u_bus_monitor (
        .sysclk      (sysclk),
        .nReset      (nReset),
        .enable_i    (enable_i),
        .dfsr_i      (dfsr_i),
        .scl_i       (scl_i),
        .sda_i       (sda_i),
        .sda_drive_i (sda_oen_o),   // 1 while master releases SDA
        .sda_chk_i   (sda_chk),
        .scl_f_o     (scl_f),
        .sda_f_o     (sda_f),
        .busy_o      (busy_o),
        .al_o        (al_o)
    );

endmodule

/* source/i2c_pkg.sv */
package i2c_pkg;

    // host side commands
    typedef enum logic [1:0] {
        BYTE_START = 2'd0,
        BYTE_WRITE = 2'd1,
        BYTE_READ  = 2'd2,
        BYTE_STOP  = 2'd3
    } byte_cmd_e;

    // one bus bit, four quarter phases each
    typedef enum logic [2:0] {
        BIT_IDLE  = 3'd0,
        BIT_START = 3'd1,
        BIT_STOP  = 3'd2,
        BIT_WRITE = 3'd3,
        BIT_READ  = 3'd4
    } bit_cmd_e;

endpackage

/* verif/i2c_master_assert.sv */
module i2c_master_assert (
    input logic sysclk,
    input logic nReset,
    input logic enable_i,
    input logic cmd_ack_o,
    input logic scl_oen_o,
    input logic sda_oen_o,
    input logic al_o
);
    ack_pulse: assert property (@(posedge sysclk) disable iff (!nReset)
        cmd_ack_o |=> !cmd_ack_o)
        else $error("cmd_ack_o held high for more than one cycle");

    // registered outputs need one cycle to let go
    idle_release: assert property (@(posedge sysclk) disable iff (!nReset)
        (!enable_i && $past(!enable_i)) |-> (scl_oen_o && sda_oen_o))
        else $error("bus line driven while controller disabled");

    al_release: assert property (@(posedge sysclk) disable iff (!nReset)
        $rose(al_o) |=> (scl_oen_o && sda_oen_o))
        else $error("bus line still driven after arbitration loss");

endmodule

bind i2c_master_top i2c_master_assert u_master_assert (
    .sysclk    (sysclk),
    .nReset    (nReset),
    .enable_i  (enable_i),
    .cmd_ack_o (cmd_ack_o),
    .scl_oen_o (scl_oen_o),
    .sda_oen_o (sda_oen_o),
    .al_o      (al_o)
);

/* verif/i2c_slave_model.sv */
module i2c_slave_model (
    input  logic       sysclk,
    input  logic       nReset,
    input  logic       scl_oen_m_i,
    input  logic       sda_oen_m_i,
    input  logic       force_sda_low_i,
    input  logic [7:0] stretch_i,
    output logic       scl_o,
    output logic       sda_o
);
    localparam logic [6:0] SLV_ADDR = 7'h50;
    localparam logic [2:0] P_IDLE   = 3'd0;
    localparam logic [2:0] P_ADDR   = 3'd1;
    localparam logic [2:0] P_REG    = 3'd2;
    localparam logic [2:0] P_WDATA  = 3'd3;
    localparam logic [2:0] P_RDATA  = 3'd4;

    logic [7:0] mem [0:15];
    logic [2:0] phase;
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic [7:0] tx;
    logic [3:0] ptr;
    logic       ack_slot;
    logic       rw;
    logic       match;
    logic       nack_q;
    logic       scl_q;
    logic       sda_q;
    logic       sda_drv;
    logic       next_drv;
    logic [1:0] hold_cnt;
    logic [7:0] stretch_cnt;

    // wired-AND of master and slave
    assign scl_o = scl_oen_m_i & (stretch_cnt == 8'd0);
    assign sda_o = sda_oen_m_i & ~sda_drv & ~force_sda_low_i;

    always_ff @(posedge sysclk or negedge nReset)
    begin
        if (!nReset)
        begin
            for (int i = 0; i < 16; i++)
                mem[i] <= {4'hA, i[3:0]};
            phase       <= P_IDLE;
            bit_cnt     <= 4'd0;
            shreg       <= 8'd0;
            tx          <= 8'd0;
            ptr         <= 4'd0;
            ack_slot    <= 1'b0;
            rw          <= 1'b0;
            match       <= 1'b0;
            nack_q      <= 1'b1;
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            sda_drv     <= 1'b0;
            next_drv    <= 1'b0;
            hold_cnt    <= 2'd0;
            stretch_cnt <= 8'd0;
        end
        else
        begin
            scl_q <= scl_o;
            sda_q <= sda_o;
            if (stretch_cnt != 8'd0)
                stretch_cnt <= stretch_cnt - 8'd1;
            if (hold_cnt == 2'd1)
                sda_drv <= next_drv;    // data change well inside SCL low
            if (hold_cnt != 2'd0)
                hold_cnt <= hold_cnt - 2'd1;

            if (scl_o && scl_q && sda_q && !sda_o)
            begin
                phase    <= P_ADDR;     // start
                bit_cnt  <= 4'd0;
                ack_slot <= 1'b0;
                sda_drv  <= 1'b0;
                hold_cnt <= 2'd0;
            end
            else if (scl_o && scl_q && !sda_q && sda_o)
            begin
                phase    <= P_IDLE;     // stop
                ack_slot <= 1'b0;
                sda_drv  <= 1'b0;
                hold_cnt <= 2'd0;
            end
            else if (scl_o && !scl_q && phase != P_IDLE)
            begin
                if (ack_slot)
                    nack_q <= sda_o;
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    shreg   <= {shreg[6:0], sda_o};
                end
            end
            else if (!scl_o && scl_q && phase != P_IDLE)
            begin
                stretch_cnt <= stretch_i;
                hold_cnt    <= 2'd2;
                if (ack_slot)
                begin
                    ack_slot <= 1'b0;
                    bit_cnt  <= 4'd0;
                    next_drv <= 1'b0;
                    case (phase)
                        P_ADDR:
                        begin
                            if (!match)
                                phase <= P_IDLE;
                            else if (rw)
                            begin
                                phase    <= P_RDATA;
                                tx       <= mem[ptr];
                                ptr      <= ptr + 4'd1;
                                next_drv <= ~mem[ptr][7];
                            end
                            else
                                phase <= P_REG;
                        end
                        P_RDATA:
                        begin
                            if (nack_q)
                                phase <= P_IDLE;    // master is done reading
                            else
                            begin
                                tx       <= mem[ptr];
                                ptr      <= ptr + 4'd1;
                                next_drv <= ~mem[ptr][7];
                            end
                        end
                        P_REG:
                        begin
                            phase <= P_WDATA;
                        end
                        default:
                        begin
                            phase <= phase;
                        end
                    endcase
                end
                else if (bit_cnt == 4'd8)
                begin
                    ack_slot <= 1'b1;
                    next_drv <= 1'b0;
                    case (phase)
                        P_ADDR:
                        begin
                            match    <= (shreg[7:1] == SLV_ADDR);
                            rw       <= shreg[0];
                            next_drv <= (shreg[7:1] == SLV_ADDR);
                        end
                        P_REG:
                        begin
                            ptr      <= shreg[3:0];
                            next_drv <= 1'b1;
                        end
                        P_WDATA:
                        begin
                            mem[ptr] <= shreg;
                            ptr      <= ptr + 4'd1;
                            next_drv <= 1'b1;
                        end
                        default:
                        begin
                            next_drv <= 1'b0;   // master owns the ack bit
                        end
                    endcase
                end
                else if (phase == P_RDATA)
                    next_drv <= ~tx[3'd7 - bit_cnt[2:0]];
                else
                    next_drv <= 1'b0;
            end
        end
    end

endmodule

/* verif/tb_clock.sv */
module tb_clock (
    output logic sysclk_o,
    output logic nReset_o
);
    initial
    begin
        sysclk_o = 1'b0;
        forever #10 sysclk_o = ~sysclk_o;   // 20 unit period
    end

    initial
    begin
        nReset_o = 1'b0;
        repeat (4) @(posedge sysclk_o);
        nReset_o <= 1'b1;
    end

endmodule

/* verif/tb_i2c_master.sv */
`include "i2c_params.svh"

module tb_i2c_master;
    localparam int TIMEOUT_CYCLES = 60000;

    logic                       sysclk;
    logic                       nReset;
    logic                       enable_i;
    logic [`I2C_PRESCALE_W-1:0] prescale_i;
    logic [`I2C_DFSR_W-1:0]     dfsr_i;
    logic                       cmd_stb_i;
    i2c_pkg::byte_cmd_e         cmd_i;
    logic [7:0]                 data_i;
    logic                       ack_i;
    logic                       cmd_ack_o;
    logic [7:0]                 data_o;
    logic                       rx_ack_o;
    logic                       al_o;
    logic                       busy_o;
    logic                       scl_o;
    logic                       scl_oen_o;
    logic                       sda_o;
    logic                       sda_oen_o;
    logic                       scl_bus;
    logic                       sda_bus;
    logic                       force_sda_low;
    logic [7:0]                 stretch;
    int                         errors;
    int                         checks;
    int                         cycles;
    logic [31:0]                rnd_state;
    logic [7:0]                 wr_bytes [0:3];

    tb_clock u_clock (
        .sysclk_o (sysclk),
        .nReset_o (nReset)
    );

    i2c_master_top u_i2c_master_top (
        .sysclk     (sysclk),
        .nReset     (nReset),
        .enable_i   (enable_i),
        .prescale_i (prescale_i),
        .dfsr_i     (dfsr_i),
        .cmd_stb_i  (cmd_stb_i),
        .cmd_i      (cmd_i),
        .data_i     (data_i),
        .ack_i      (ack_i),
        .cmd_ack_o  (cmd_ack_o),
        .data_o     (data_o),
        .rx_ack_o   (rx_ack_o),
        .al_o       (al_o),
        .busy_o     (busy_o),
        .scl_i      (scl_bus),
        .scl_o      (scl_o),
        .scl_oen_o  (scl_oen_o),
        .sda_i      (sda_bus),
        .sda_o      (sda_o),
        .sda_oen_o  (sda_oen_o)
    );

    i2c_slave_model u_slave (
        .sysclk          (sysclk),
        .nReset          (nReset),
        .scl_oen_m_i     (scl_oen_o),
        .sda_oen_m_i     (sda_oen_o),
        .force_sda_low_i (force_sda_low),
        .stretch_i       (stretch),
        .scl_o           (scl_bus),
        .sda_o           (sda_bus)
    );

    function automatic logic [31:0] next_rand();
        rnd_state = rnd_state ^ (rnd_state << 13);
        rnd_state = rnd_state ^ (rnd_state >> 17);
        rnd_state = rnd_state ^ (rnd_state << 5);
        return rnd_state;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("ERR %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic issue(input i2c_pkg::byte_cmd_e cmd, input logic [7:0] data,
                         input logic ack);
        @(posedge sysclk);
        cmd_stb_i <= 1'b1;
        cmd_i     <= cmd;
        data_i    <= data;
        ack_i     <= ack;
        @(posedge sysclk);
        cmd_stb_i <= 1'b0;
        do
            @(posedge sysclk);
        while (cmd_ack_o !== 1'b1);
    endtask

    task automatic wait_bus_free(input string name);
        int n;
        n = 0;
        while (busy_o !== 1'b0 && n < 100)
        begin
            @(posedge sysclk);
            n++;
        end
        if (busy_o !== 1'b0)
        begin
            errors++;
            $display("%s: bus still busy long after the STOP", name);
        end
    endtask

    task automatic write_bytes(input string name, input logic [3:0] index, input int count);
        logic [31:0] rnd;
        issue(i2c_pkg::BYTE_START, 8'h00, 1'b1);
        check({name, " busy"}, 1, busy_o);
        issue(i2c_pkg::BYTE_WRITE, 8'hA0, 1'b1);
        check({name, " addr ack"}, 0, rx_ack_o);
        issue(i2c_pkg::BYTE_WRITE, {4'h0, index}, 1'b1);
        check({name, " index ack"}, 0, rx_ack_o);
        for (int i = 0; i < count; i++)
        begin
            rnd         = next_rand();
            wr_bytes[i] = rnd[7:0];
            issue(i2c_pkg::BYTE_WRITE, wr_bytes[i], 1'b1);
            check({name, " data ack"}, 0, rx_ack_o);
        end
        issue(i2c_pkg::BYTE_STOP, 8'h00, 1'b1);
        wait_bus_free(name);
        check({name, " idle"}, 0, busy_o);
        for (int i = 0; i < count; i++)
            check({name, " mem"}, wr_bytes[i], u_slave.mem[index + i[3:0]]);
    endtask

    task automatic idle_after_reset();
        wait (nReset === 1'b1);
        repeat (2) @(posedge sysclk);
        check("reset scl_oen", 1, scl_oen_o);
        check("reset sda_oen", 1, sda_oen_o);
        check("reset scl_o", 0, scl_o);
        check("reset sda_o", 0, sda_o);
        check("reset cmd_ack", 0, cmd_ack_o);
        check("reset busy", 0, busy_o);
        check("reset rx_ack", 1, rx_ack_o);
        check("reset al", 0, al_o);
        enable_i <= 1'b1;
        @(posedge sysclk);
    endtask

    task automatic read_back();
        issue(i2c_pkg::BYTE_START, 8'h00, 1'b1);
        issue(i2c_pkg::BYTE_WRITE, 8'hA0, 1'b1);
        issue(i2c_pkg::BYTE_WRITE, 8'h03, 1'b1);
        issue(i2c_pkg::BYTE_STOP, 8'h00, 1'b1);
        wait_bus_free("read setup");
        issue(i2c_pkg::BYTE_START, 8'h00, 1'b1);
        issue(i2c_pkg::BYTE_WRITE, 8'hA1, 1'b1);
        check("read addr ack", 0, rx_ack_o);
        for (int i = 0; i < 4; i++)
        begin
            issue(i2c_pkg::BYTE_READ, 8'h00, (i == 3));   // nack the last byte
            check("read data", wr_bytes[i], data_o);
        end
        issue(i2c_pkg::BYTE_STOP, 8'h00, 1'b1);
        wait_bus_free("read");
    endtask

    task automatic address_nack();
        issue(i2c_pkg::BYTE_START, 8'h00, 1'b1);
        issue(i2c_pkg::BYTE_WRITE, {7'h21, 1'b0}, 1'b1);
        check("nack addr", 1, rx_ack_o);
        issue(i2c_pkg::BYTE_STOP, 8'h00, 1'b1);
        wait_bus_free("nack");
    endtask

    task automatic arbitration_loss();
        issue(i2c_pkg::BYTE_START, 8'h00, 1'b1);
        force_sda_low <= 1'b1;      // SCL is low after START
        issue(i2c_pkg::BYTE_WRITE, 8'hFF, 1'b1);
        check("arb al", 1, al_o);
        check("arb scl_oen", 1, scl_oen_o);
        check("arb sda_oen", 1, sda_oen_o);
        force_sda_low <= 1'b0;
        wait_bus_free("arb");
        check("arb al held", 1, al_o);
        check("arb oen held", 2'b11, {scl_oen_o, sda_oen_o});
        issue(i2c_pkg::BYTE_START, 8'h00, 1'b1);
        check("arb al cleared", 0, al_o);
        issue(i2c_pkg::BYTE_STOP, 8'h00, 1'b1);
        wait_bus_free("arb recover");
    endtask

    always @(posedge sysclk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    initial
    begin
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        rnd_state     = 32'h4131;
        enable_i      <= 1'b0;
        prescale_i    <= 16'd4;
        dfsr_i        <= 16'd0;
        cmd_stb_i     <= 1'b0;
        cmd_i         <= i2c_pkg::BYTE_START;
        data_i        <= 8'h00;
        ack_i         <= 1'b1;
        force_sda_low <= 1'b0;
        stretch       <= 8'd0;

        idle_after_reset();
        write_bytes("write", 4'h3, 4);
        read_back();
        address_nack();
        stretch <= 8'd37;
        write_bytes("stretch", 4'h8, 2);
        stretch <= 8'd0;
        arbitration_loss();

        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
